//--- rv32_decode.f
rv32_isa_pkg.sv
decode_stage_pkg.sv
opcode_classifier.sv
alu_op_decoder.sv
imm_generator.sv
decode_pipe_reg.sv
instr_decode.sv
instr_decode_properties.sv
tb_instr_decode.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_instr_decode \
  -f rv32_decode.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "build or simulation returned an error"
[ -f sim.log ] && cat sim.log
grep -q '\*\*\* TEST PASSED \*\*\*' sim.log 2>/dev/null \
  && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }

//--- tb_instr_decode.sv
// decode stage testbench
`timescale 1ns/1ps

module tb_instr_decode;

  import rv32_isa_pkg::*;
  import decode_stage_pkg::*;

  localparam int  CLK_PERIOD   = 40;
  localparam int  RESET_CYCLES = 8;
  localparam time DRIVE_DELAY  = 2;
  localparam int  NUM_RANDOM   = 300;
  localparam int  DRAIN_LIMIT  = 20;

  logic        clk;
  logic        rstn;
  logic [31:0] fetch_instr_i;
  logic [31:0] fetch_pc_i;
  logic        decode_en_i;
  logic        decode_stall_i;
  logic        decode_flush_i;
  logic [4:0]  rf_rs1_addr_o;
  logic [4:0]  rf_rs2_addr_o;
  decoded_t    decode_o;
  logic        execute_en_o;

  int          checks;
  int          errors;
  logic [31:0] lcg_state;
  logic [31:0] pc;
  decoded_t    exp_q[$];   // one entry per captured instruction
  string       name_q[$];
  logic [6:0]  legal_ops [0:10];

  instr_decode dut0 (
    .clk            (clk),
    .rstn           (rstn),
    .fetch_instr_i  (fetch_instr_i),
    .fetch_pc_i     (fetch_pc_i),
    .decode_en_i    (decode_en_i),
    .decode_stall_i (decode_stall_i),
    .decode_flush_i (decode_flush_i),
    .rf_rs1_addr_o  (rf_rs1_addr_o),
    .rf_rs2_addr_o  (rf_rs2_addr_o),
    .decode_o       (decode_o),
    .execute_en_o   (execute_en_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // whole run limit
  initial begin
    #(CLK_PERIOD * 5000);
    $display("timeout: simulation did not reach its end");
    $display("*** TEST FAILED ***");
    $finish;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] make_instr(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  // register op table shared by rtype and itype
  function automatic alu_op_e base_alu(input logic [2:0] f3);
    case (f3)
      3'd0:    return ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // expected bundle from the isa rules
  function automatic decoded_t ref_decode(input logic [31:0] ins, input logic [31:0] pc_v);
    decoded_t   d;
    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       s;
    op = ins[6:0];
    f3 = ins[14:12];
    f7 = ins[31:25];
    s  = ins[31];
    d        = '0;
    d.pc     = pc_v;
    d.rs1    = ins[19:15];
    d.rs2    = ins[24:20];
    d.rd     = ins[11:7];
    d.funct3 = f3;
    case (op)
      7'h33:   d.opclass = OPC_RTYPE;
      7'h13:   d.opclass = OPC_ITYPE;
      7'h03:   d.opclass = OPC_LOAD;
      7'h23:   d.opclass = OPC_STORE;
      7'h63:   d.opclass = OPC_BRANCH;
      7'h6F:   d.opclass = OPC_JAL;
      7'h67:   d.opclass = OPC_JALR;
      7'h37:   d.opclass = OPC_LUI;
      7'h17:   d.opclass = OPC_AUIPC;
      7'h73:   d.opclass = OPC_SYSTEM;
      7'h0F:   d.opclass = OPC_FENCE;
      default: d.opclass = OPC_INVALID;
    endcase
    d.exc.illegal = (d.opclass == OPC_INVALID);
    d.alu_op = ALU_ADD;
    if (d.opclass == OPC_RTYPE) begin
      if (f7 == 7'h00) d.alu_op = base_alu(f3);
      else if (f7 == 7'h20 && f3 == 3'd0) d.alu_op = ALU_SUB;
      else if (f7 == 7'h20 && f3 == 3'd5) d.alu_op = ALU_SRA;
      else d.alu_op = ALU_NONE;
    end else if (d.opclass == OPC_ITYPE) begin
      if (f3 != 3'd5) d.alu_op = base_alu(f3);
      else if (f7 == 7'h00) d.alu_op = ALU_SRL;
      else if (f7 == 7'h20) d.alu_op = ALU_SRA;
      else d.alu_op = ALU_NONE;
      if (ins[25] && (d.alu_op == ALU_SLL || d.alu_op == ALU_SRL || d.alu_op == ALU_SRA))
        d.exc.illegal = 1'b1;  // shamt wider than 5 bits
    end else if (d.opclass == OPC_BRANCH) begin
      case (f3)
        3'd0:    d.alu_op = ALU_EQ;
        3'd1:    d.alu_op = ALU_NEQ;
        3'd4:    d.alu_op = ALU_SLT;
        3'd5:    d.alu_op = ALU_GE;
        3'd6:    d.alu_op = ALU_SLTU;
        3'd7:    d.alu_op = ALU_GEU;
        default: d.alu_op = ALU_NONE;
      endcase
    end
    case (d.opclass)
      OPC_ITYPE, OPC_LOAD, OPC_JALR: d.imm = {{20{s}}, ins[31:20]};
      OPC_STORE:  d.imm = {{20{s}}, ins[31:25], ins[11:7]};
      OPC_BRANCH: d.imm = {{20{s}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      OPC_JAL:    d.imm = {{12{s}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      OPC_LUI, OPC_AUIPC:    d.imm = {ins[31:12], 12'h000};
      OPC_SYSTEM, OPC_FENCE: d.imm = {20'h00000, ins[31:20]};
      default:    d.imm = '0;
    endcase
    if (d.opclass == OPC_SYSTEM && f3 == 3'd0) begin
      d.exc.ecall  = (ins[21:20] == 2'b00);
      d.exc.ebreak = (ins[21:20] == 2'b01);
      d.exc.mret   = (ins[21:20] == 2'b10);
    end
    return d;
  endfunction

  // one instruction per cycle and queued for the compare process
  task automatic drive_instr(input logic [31:0] ins, input string name);
    @(posedge clk);
    #DRIVE_DELAY;
    fetch_instr_i  = ins;
    fetch_pc_i     = pc;
    decode_en_i    = 1'b1;
    decode_stall_i = 1'b0;
    decode_flush_i = 1'b0;
    exp_q.push_back(ref_decode(ins, pc));
    name_q.push_back(name);
    pc = pc + 32'd4;
    #1;
    checks++;
    if (rf_rs1_addr_o !== ins[19:15] || rf_rs2_addr_o !== ins[24:20]) begin
      errors++;
      $display("FAIL %s rf_addr: expected %h/%h actual %h/%h", name, ins[19:15],
               ins[24:20], rf_rs1_addr_o, rf_rs2_addr_o);
    end
  endtask

  task automatic wait_drain(input string name);
    int n;
    n = 0;
    while (exp_q.size() > 0 && n < DRAIN_LIMIT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      n++;
    end
    if (exp_q.size() > 0) begin
      errors++;
      $display("%s: timed out waiting for the compare queue to empty", name);
    end
  endtask

  task automatic end_test(input string name, input int start);
    $display("test %-12s done, %0d errors", name, errors - start);
  endtask

  // compare one cycle after each capture
  initial begin : compare_proc
    decoded_t exp_d;
    string    nm;
    forever begin
      @(posedge clk);
      #1;
      if (exp_q.size() > 0) begin
        exp_d = exp_q.pop_front();
        nm    = name_q.pop_front();
        checks++;
        if (decode_o !== exp_d) begin
          errors++;
          $display("FAIL %s: expected %h actual %h", nm, exp_d, decode_o);
        end
        if (execute_en_o !== 1'b1) begin
          errors++;
          $display("FAIL %s execute_en: expected 1 actual %b", nm, execute_en_o);
        end
      end
    end
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin : main_seq
    int          start;
    int          i;
    int          sel;
    logic [31:0] r;
    logic [6:0]  op;
    logic [6:0]  f7;
    decoded_t    held_d;
    logic        held_en;
    logic [6:0]  f7_r [0:3];
    logic [6:0]  f7_i [0:3];
    logic [6:0]  other_ops [0:6];
    logic [6:0]  bad_ops [0:3];
    legal_ops = '{7'h33, 7'h13, 7'h03, 7'h23, 7'h63, 7'h6F, 7'h67, 7'h37, 7'h17,
                  7'h73, 7'h0F};
    f7_r      = '{7'h00, 7'h20, 7'h01, 7'h40};
    f7_i      = '{7'h00, 7'h20, 7'h01, 7'h21};
    other_ops = '{7'h03, 7'h23, 7'h6F, 7'h67, 7'h37, 7'h17, 7'h0F};
    bad_ops   = '{7'h00, 7'h7F, 7'h0B, 7'h5B};
    checks         = 0;
    errors         = 0;
    lcg_state      = 32'h1d8c_a004;
    pc             = 32'h0000_1000;
    rstn           = 1'b0;
    fetch_instr_i  = '0;
    fetch_pc_i     = '0;
    decode_en_i    = 1'b0;
    decode_stall_i = 1'b0;
    decode_flush_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rstn = 1'b1;

    // reset state
    start = errors;
    #1;
    checks++;
    if (execute_en_o !== 1'b0) begin
      errors++;
      $display("FAIL reset execute_en: expected 0 actual %b", execute_en_o);
    end
    checks++;
    if (decode_o !== '0) begin
      errors++;
      $display("FAIL reset decode_o: expected %h actual %h", decoded_t'('0), decode_o);
    end
    end_test("reset", start);

    // alu decode
    start = errors;
    for (i = 0; i < 32; i++) begin
      drive_instr(make_instr(f7_r[i / 8], 5'd7, 5'd3, i[2:0], 5'd9, 7'h33), "alu_rtype");
      drive_instr(make_instr(f7_i[i / 8], 5'd4, 5'd5, i[2:0], 5'd1, 7'h13), "alu_itype");
    end
    for (i = 0; i < 8; i++) begin
      drive_instr(make_instr(7'h12, 5'd2, 5'd6, i[2:0], 5'd14, 7'h63), "alu_branch");
    end
    for (i = 0; i < 7; i++) begin
      drive_instr(make_instr(7'h05, 5'd8, 5'd10, 3'd2, 5'd11, other_ops[i]), "alu_other");
    end
    wait_drain("alu_decode");
    end_test("alu_decode", start);

    // immediates with both sign values for every format
    start = errors;
    for (i = 0; i < 22; i++) begin
      r = lcg_next();
      drive_instr({i[0], r[30:7], legal_ops[i / 2]}, "immediate");
    end
    wait_drain("immediate");
    end_test("immediate", start);

    // exceptions
    start = errors;
    for (i = 0; i < 4; i++) begin
      drive_instr(make_instr(7'h00, 5'd1, 5'd2, 3'd0, 5'd3, bad_ops[i]), "exc_opcode");
    end
    drive_instr(make_instr(7'h01, 5'd3, 5'd2, 3'd1, 5'd4, 7'h13), "exc_shift");
    drive_instr(make_instr(7'h21, 5'd3, 5'd2, 3'd5, 5'd4, 7'h13), "exc_shift");
    drive_instr(make_instr(7'h01, 5'd3, 5'd2, 3'd5, 5'd4, 7'h13), "exc_shift");
    drive_instr(make_instr(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, 7'h73), "exc_ecall");
    drive_instr(make_instr(7'h00, 5'd1, 5'd0, 3'd0, 5'd0, 7'h73), "exc_ebreak");
    drive_instr(make_instr(7'h18, 5'd2, 5'd0, 3'd0, 5'd0, 7'h73), "exc_mret");
    drive_instr(make_instr(7'h00, 5'd3, 5'd0, 3'd0, 5'd0, 7'h73), "exc_sys11");
    drive_instr(make_instr(7'h18, 5'd0, 5'd1, 3'd1, 5'd2, 7'h73), "exc_csr");
    wait_drain("exception");
    end_test("exception", start);

    // stall, flush and enable
    start = errors;
    drive_instr(make_instr(7'h20, 5'd5, 5'd6, 3'd0, 5'd7, 7'h33), "stall_setup");
    wait_drain("stall_setup");
    fetch_instr_i  = make_instr(7'h00, 5'd9, 5'd9, 3'd7, 5'd9, 7'h13);
    decode_stall_i = 1'b1;
    decode_flush_i = 1'b1;  // would clear execute_en_o without the stall
    held_d         = decode_o;
    held_en        = execute_en_o;
    repeat (3) begin
      @(posedge clk);
      #1;
      checks++;
      if (decode_o !== held_d || execute_en_o !== held_en) begin
        errors++;
        $display("FAIL stall: expected %h/%b actual %h/%b", held_d, held_en,
                 decode_o, execute_en_o);
      end
    end
    #1;
    decode_stall_i = 1'b0;
    @(posedge clk);
    #1;
    checks++;
    if (execute_en_o !== 1'b0) begin
      errors++;
      $display("FAIL flush execute_en: expected 0 actual %b", execute_en_o);
    end
    #1;
    decode_flush_i = 1'b0;
    @(posedge clk);
    #1;
    checks++;
    if (execute_en_o !== 1'b1) begin
      errors++;
      $display("FAIL enable_high execute_en: expected 1 actual %b", execute_en_o);
    end
    #1;
    decode_en_i = 1'b0;
    @(posedge clk);
    #1;
    checks++;
    if (execute_en_o !== 1'b0) begin
      errors++;
      $display("FAIL enable_low execute_en: expected 0 actual %b", execute_en_o);
    end
    end_test("stall_flush", start);

    // random run
    start = errors;
    for (i = 0; i < NUM_RANDOM; i++) begin
      r   = lcg_next();
      sel = int'(lcg_next() % 32'd16);
      op  = (sel < 11) ? legal_ops[sel] : r[6:0];  // sometimes an unknown opcode
      case (lcg_next() % 32'd4)
        32'd0:   f7 = 7'h00;
        32'd1:   f7 = 7'h20;
        default: f7 = r[31:25];
      endcase
      drive_instr({f7, r[24:7], op}, "random");
    end
    wait_drain("random");
    end_test("random", start);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- instr_decode_properties.sv
// decode stage assertions
`timescale 1ns/1ps

module instr_decode_properties (
  input logic                       clk,
  input logic                       rstn,
  input logic                       decode_stall_i,
  input logic                       decode_flush_i,
  input decode_stage_pkg::decoded_t decode_o,
  input logic                       execute_en_o
);

  // no enable toward execute under reset
  a_reset_en : assert property (@(posedge clk) !rstn |-> !execute_en_o)
    else $error("execute_en_o high during reset");

  a_stall_hold : assert property (@(posedge clk) disable iff (!rstn)
    decode_stall_i |=> ($stable(decode_o) && $stable(execute_en_o)))
    else $error("stage output changed under stall");

  // a flushed slot is a bubble
  a_flush_bubble : assert property (@(posedge clk) disable iff (!rstn)
    (decode_flush_i && !decode_stall_i) |=> !execute_en_o)
    else $error("execute_en_o high after flush");

endmodule

bind instr_decode instr_decode_properties props0 (
  .clk            (clk),
  .rstn           (rstn),
  .decode_stall_i (decode_stall_i),
  .decode_flush_i (decode_flush_i),
  .decode_o       (decode_o),
  .execute_en_o   (execute_en_o)
);

//--- instr_decode.sv
// rv32 instruction decode stage
`timescale 1ns/1ps

module instr_decode (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic [rv32_isa_pkg::ILEN-1:0]       fetch_instr_i,
  input  logic [rv32_isa_pkg::XLEN-1:0]       fetch_pc_i,
  input  logic                                decode_en_i,
  input  logic                                decode_stall_i,
  input  logic                                decode_flush_i,
  output logic [rv32_isa_pkg::REG_ADDR_W-1:0] rf_rs1_addr_o,  // unregistered
  output logic [rv32_isa_pkg::REG_ADDR_W-1:0] rf_rs2_addr_o,  // unregistered
  output decode_stage_pkg::decoded_t          decode_o,
  output logic                                execute_en_o
);

  import rv32_isa_pkg::*;
  import decode_stage_pkg::*;

  opclass_e        opclass;
  alu_op_e         alu_op;
  exc_t            sys_exc;
  logic            illegal_shift;
  logic [XLEN-1:0] imm;
  decoded_t        next_bundle;

  // the register file registers its own read address
  assign rf_rs1_addr_o = fetch_instr_i[19:15];
  assign rf_rs2_addr_o = fetch_instr_i[24:20];

  //////////////////////////////
  // decoders
  //////////////////////////////

  opcode_classifier u_classifier (
    .instr_i   (fetch_instr_i),
    .opclass_o (opclass),
    .sys_exc_o (sys_exc)
  );

  alu_op_decoder u_alu_dec (
    .instr_i         (fetch_instr_i),
    .opclass_i       (opclass),
    .alu_op_o        (alu_op),
    .illegal_shift_o (illegal_shift)
  );

  imm_generator u_imm_gen (
    .instr_i   (fetch_instr_i),
    .opclass_i (opclass),
    .imm_o     (imm)
  );

  // assemble the bundle for execute
  always_comb begin
    next_bundle             = '0;
    next_bundle.pc          = fetch_pc_i;
    next_bundle.rs1         = rf_rs1_addr_o;
    next_bundle.rs2         = rf_rs2_addr_o;
    next_bundle.rd          = fetch_instr_i[11:7];
    next_bundle.funct3      = fetch_instr_i[14:12];
    next_bundle.imm         = imm;
    next_bundle.opclass     = opclass;
    next_bundle.alu_op      = alu_op;
    next_bundle.exc         = sys_exc;
    next_bundle.exc.illegal = sys_exc.illegal || illegal_shift;
  end

  decode_pipe_reg u_pipe_reg (
    .clk          (clk),
    .rstn         (rstn),
    .en_i         (decode_en_i),
    .stall_i      (decode_stall_i),
    .flush_i      (decode_flush_i),
    .next_i       (next_bundle),
    .decode_o     (decode_o),
    .execute_en_o (execute_en_o)
  );

endmodule

//--- decode_pipe_reg.sv
// decode to execute stage register
`timescale 1ns/1ps

module decode_pipe_reg (
  input  logic                       clk,
  input  logic                       rstn,
  input  logic                       en_i,       // this stage's clock enable
  input  logic                       stall_i,    // hold everything
  input  logic                       flush_i,    // kill the next enable
  input  decode_stage_pkg::decoded_t next_i,
  output decode_stage_pkg::decoded_t decode_o,
  output logic                       execute_en_o
);

  logic capture;

  // bundle loads only on an enabled, unstalled edge
  assign capture = en_i && !stall_i;

  //////////////////////////////
  // payload
  //////////////////////////////

  // flush does not block the load, execute_en_o qualifies it
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      decode_o <= '0;  // invalid class, no alu op, no exceptions
    end else if (capture) begin
      decode_o <= next_i;
    end
  end

  //////////////////////////////
  // next stage enable
  //////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      execute_en_o <= 1'b0;
    end else if (!stall_i) begin
      // flush leaves a bubble for execute
      execute_en_o <= en_i && !flush_i;
    end
  end

endmodule

//--- imm_generator.sv
// immediate generator
`timescale 1ns/1ps

module imm_generator (
  input  logic [rv32_isa_pkg::ILEN-1:0] instr_i,
  input  rv32_isa_pkg::opclass_e        opclass_i,
  output logic [rv32_isa_pkg::XLEN-1:0] imm_o
);

  import rv32_isa_pkg::*;

  logic            sign;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_x;

  assign sign = instr_i[31];

  //////////////////////////////
  // formats
  //////////////////////////////

  assign imm_i = {{20{sign}}, instr_i[31:20]};
  assign imm_s = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{sign}}, sign, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_j = {{11{sign}}, sign, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
  assign imm_u = {instr_i[31:12], 12'h000};
  assign imm_x = {20'h00000, instr_i[31:20]};  // csr address, fence bits

  always_comb begin
    case (opclass_i)
      OPC_ITYPE, OPC_LOAD, OPC_JALR: imm_o = imm_i;
      OPC_STORE:                     imm_o = imm_s;
      OPC_BRANCH:                    imm_o = imm_b;
      OPC_JAL:                       imm_o = imm_j;
      OPC_LUI, OPC_AUIPC:            imm_o = imm_u;
      OPC_SYSTEM, OPC_FENCE:         imm_o = imm_x;
      default:                       imm_o = '0;  // rtype has no immediate
    endcase
  end

endmodule

//--- alu_op_decoder.sv
// alu operation decoder
`timescale 1ns/1ps

module alu_op_decoder (
  input  logic [rv32_isa_pkg::ILEN-1:0] instr_i,
  input  rv32_isa_pkg::opclass_e        opclass_i,
  output rv32_isa_pkg::alu_op_e         alu_op_o,
  output logic                          illegal_shift_o
);

  import rv32_isa_pkg::*;

  logic [FUNCT3_W-1:0] funct3;
  logic [FUNCT7_W-1:0] funct7;
  alu_op_e             base_op;  // rtype and itype with funct7 zero

  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  //////////////////////////////
  // common register ops
  //////////////////////////////

  always_comb begin
    case (funct3)
      F3_ADD:  base_op = ALU_ADD;
      F3_SLL:  base_op = ALU_SLL;
      F3_SLT:  base_op = ALU_SLT;
      F3_SLTU: base_op = ALU_SLTU;
      F3_XOR:  base_op = ALU_XOR;
      F3_SRL:  base_op = ALU_SRL;
      F3_OR:   base_op = ALU_OR;
      F3_AND:  base_op = ALU_AND;
      default: base_op = ALU_NONE;
    endcase
  end

  //////////////////////////////
  // select by class
  //////////////////////////////

  always_comb begin
    alu_op_o = ALU_ADD;  // address calc and friends
    case (opclass_i)
      OPC_RTYPE: begin
        if (funct7 == FUNCT7_BASE) begin
          alu_op_o = base_op;
        end else if (funct7 == FUNCT7_ALT && funct3 == F3_ADD) begin
          alu_op_o = ALU_SUB;
        end else if (funct7 == FUNCT7_ALT && funct3 == F3_SRL) begin
          alu_op_o = ALU_SRA;
        end else begin
          alu_op_o = ALU_NONE;
        end
      end
      OPC_ITYPE: begin
        if (funct3 != F3_SRL)           alu_op_o = base_op;  // no subi
        else if (funct7 == FUNCT7_BASE) alu_op_o = ALU_SRL;
        else if (funct7 == FUNCT7_ALT)  alu_op_o = ALU_SRA;
        else                            alu_op_o = ALU_NONE;
      end
      OPC_BRANCH: begin
        case (funct3)
          F3_BEQ:  alu_op_o = ALU_EQ;
          F3_BNE:  alu_op_o = ALU_NEQ;
          F3_BLT:  alu_op_o = ALU_SLT;
          F3_BGE:  alu_op_o = ALU_GE;
          F3_BLTU: alu_op_o = ALU_SLTU;
          F3_BGEU: alu_op_o = ALU_GEU;
          default: alu_op_o = ALU_NONE;
        endcase
      end
      default: alu_op_o = ALU_ADD;
    endcase
  end

  // rv32 shamt is 5 bits, bit 25 set means a 64-bit shift
  assign illegal_shift_o = (opclass_i == OPC_ITYPE) && instr_i[25] &&
                           (alu_op_o inside {ALU_SLL, ALU_SRL, ALU_SRA});

endmodule

//--- opcode_classifier.sv
// opcode class and system exceptions
`timescale 1ns/1ps

module opcode_classifier (
  input  logic [rv32_isa_pkg::ILEN-1:0] instr_i,
  output rv32_isa_pkg::opclass_e        opclass_o,
  output decode_stage_pkg::exc_t        sys_exc_o
);

  import rv32_isa_pkg::*;
  import decode_stage_pkg::*;

  opcode_e             opcode;
  logic [FUNCT3_W-1:0] funct3;
  logic                sys_noncsr;  // system but not a csr access

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];

  always_comb begin
    case (opcode)
      OP_RTYPE:  opclass_o = OPC_RTYPE;
      OP_ITYPE:  opclass_o = OPC_ITYPE;
      OP_LOAD:   opclass_o = OPC_LOAD;
      OP_STORE:  opclass_o = OPC_STORE;
      OP_BRANCH: opclass_o = OPC_BRANCH;
      OP_JAL:    opclass_o = OPC_JAL;
      OP_JALR:   opclass_o = OPC_JALR;
      OP_LUI:    opclass_o = OPC_LUI;
      OP_AUIPC:  opclass_o = OPC_AUIPC;
      OP_SYSTEM: opclass_o = OPC_SYSTEM;
      OP_FENCE:  opclass_o = OPC_FENCE;
      default:   opclass_o = OPC_INVALID;  // no legal encoding matched
    endcase
  end

  //////////////////////////////
  // system exceptions
  //////////////////////////////

  assign sys_noncsr = (opclass_o == OPC_SYSTEM) && (funct3 == '0);

  // bits 21:20 tell ecall, ebreak and mret apart
  always_comb begin
    sys_exc_o         = '0;
    sys_exc_o.illegal = (opclass_o == OPC_INVALID);
    if (sys_noncsr) begin
      case (instr_i[21:20])
        2'b00:   sys_exc_o.ecall  = 1'b1;
        2'b01:   sys_exc_o.ebreak = 1'b1;
        2'b10:   sys_exc_o.mret   = 1'b1;
        default: sys_exc_o.ecall  = 1'b0;  // 11 raises nothing
      endcase
    end
  end

endmodule

//--- decode_stage_pkg.sv
// decode stage payload types
package decode_stage_pkg;

  import rv32_isa_pkg::*;

  //////////////////////////////
  // exceptions
  //////////////////////////////

  typedef struct packed {
    logic illegal;  // unknown opcode or bad shift
    logic ecall;
    logic ebreak;
    logic mret;
  } exc_t;

  //////////////////////////////
  // decoded bundle to execute
  //////////////////////////////

  // about 100 bits, all zero is a harmless bubble
  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [FUNCT3_W-1:0]   funct3;   // kept for load/store width and branch type
    logic [XLEN-1:0]       imm;
    opclass_e              opclass;
    alu_op_e               alu_op;
    exc_t                  exc;
  } decoded_t;

endpackage

//--- rv32_isa_pkg.sv
// rv32 base isa encodings
package rv32_isa_pkg;

  // instruction field widths
  localparam int ILEN       = 32;
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int OPCODE_W   = 7;
  localparam int FUNCT3_W   = 3;
  localparam int FUNCT7_W   = 7;

  //////////////////////////////
  // opcode field
  //////////////////////////////

  typedef enum logic [OPCODE_W-1:0] {
    OP_RTYPE  = 7'b0110011,
    OP_ITYPE  = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_SYSTEM = 7'b1110011,
    OP_FENCE  = 7'b0001111
  } opcode_e;

  // invalid must stay zero, the stage register resets to it
  typedef enum logic [3:0] {
    OPC_INVALID = 4'd0,
    OPC_RTYPE   = 4'd1,
    OPC_ITYPE   = 4'd2,
    OPC_LOAD    = 4'd3,
    OPC_STORE   = 4'd4,
    OPC_BRANCH  = 4'd5,
    OPC_JAL     = 4'd6,
    OPC_JALR    = 4'd7,
    OPC_LUI     = 4'd8,
    OPC_AUIPC   = 4'd9,
    OPC_SYSTEM  = 4'd10,
    OPC_FENCE   = 4'd11
  } opclass_e;

  //////////////////////////////
  // alu operations
  //////////////////////////////

  typedef enum logic [3:0] {
    ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL,
    ALU_SRA, ALU_EQ, ALU_NEQ, ALU_GE, ALU_GEU
  } alu_op_e;

  localparam logic [FUNCT7_W-1:0] FUNCT7_BASE = 7'h00;
  localparam logic [FUNCT7_W-1:0] FUNCT7_ALT  = 7'h20;  // sub, sra

  // funct3 for register and immediate ops
  localparam logic [FUNCT3_W-1:0] F3_ADD  = 3'd0;
  localparam logic [FUNCT3_W-1:0] F3_SLL  = 3'd1;
  localparam logic [FUNCT3_W-1:0] F3_SLT  = 3'd2;
  localparam logic [FUNCT3_W-1:0] F3_SLTU = 3'd3;
  localparam logic [FUNCT3_W-1:0] F3_XOR  = 3'd4;
  localparam logic [FUNCT3_W-1:0] F3_SRL  = 3'd5;  // also sra
  localparam logic [FUNCT3_W-1:0] F3_OR   = 3'd6;
  localparam logic [FUNCT3_W-1:0] F3_AND  = 3'd7;

  // funct3 for branches, 2 and 3 unused
  localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'd0;
  localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'd1;
  localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'd4;
  localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'd5;
  localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'd6;
  localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'd7;

endpackage
